//--- Bender.yml
package:
  name: rv32i_triple_issue_core

sources:
  - files:
      - rtl/rv_core_pkg.sv
      - rtl/bundle_issue.sv
      - rtl/exec_lane.sv
      - rtl/register_file.sv
      - rtl/rv32i_triple_issue_core.sv
  - target: test
    files:
      - testbench/core_properties.sv
      - testbench/core_tb.sv

//--- compile.f
rtl/rv_core_pkg.sv
rtl/bundle_issue.sv
rtl/exec_lane.sv
rtl/register_file.sv
rtl/rv32i_triple_issue_core.sv
testbench/core_properties.sv
testbench/core_tb.sv

//--- rtl/bundle_issue.sv
// Fetch FSM with req/ack handshake, PC, bundle capture, hazard-based
// issue count and next-PC selection
`timescale 1ns/1ns

module bundle_issue
  import rv_core_pkg::*;
(
  input  logic            clock,
  input  logic            reset_n,
  output logic            fetch_req,
  output logic [xlen-1:0] fetch_pc,
  input  logic            fetch_ack,
  input  fetch_bundle_t   fetch_words,
  output lane_issue_t     issue [lanes],
  input  lane_result_t    results [lanes]
);

  fetch_state_e          state;
  fetch_state_e          state_next;
  fetch_bundle_t         bundle_q;
  logic [xlen-1:0]       pc_q;
  logic [xlen-1:0]       pc_next;
  logic [1:0]            issue_cnt;
  logic [lanes-1:0]      issued;
  logic [lanes-1:0]      is_ctrl;
  logic [lanes-1:0]      writes_rd;
  logic [lanes-1:0]      uses_rs1;
  logic [lanes-1:0]      uses_rs2;
  logic [reg_addr_w-1:0] rd_f  [lanes];
  logic [reg_addr_w-1:0] rs1_f [lanes];
  logic [reg_addr_w-1:0] rs2_f [lanes];

  assign fetch_pc = pc_q; // Held until the execute cycle

  always_comb begin
    state_next = state;
    case (state)
      fetch_request: if (fetch_req && fetch_ack) state_next = fetch_release;
      fetch_release: if (!fetch_ack) state_next = execute;
      execute:       state_next = fetch_request; // Always a single cycle
      default:       state_next = fetch_request;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state     <= fetch_request;
      fetch_req <= 1'b0; // First request one cycle after reset
      pc_q      <= '0;
    end else begin
      state     <= state_next;
      fetch_req <= (state_next == fetch_request);
      if (state == execute) begin
        pc_q <= pc_next;
      end
    end
  end

  always_ff @(posedge clock) begin
    if ((state == fetch_request) && fetch_req && fetch_ack) begin
      bundle_q <= fetch_words;
    end
  end

  // Per-word predecode of register usage and control transfer
  for (genvar k = 0; k < lanes; k++) begin : pre_gen
    rv_opcode_e op;

    assign op       = rv_opcode_e'(bundle_q.words[k][6:0]);
    assign rd_f[k]  = bundle_q.words[k][11:7];
    assign rs1_f[k] = bundle_q.words[k][19:15];
    assign rs2_f[k] = bundle_q.words[k][24:20];

    assign writes_rd[k] = (rd_f[k] != '0) &&
                          (op inside {op_reg, op_imm, op_lui, op_auipc, op_jal, op_jalr});
    assign uses_rs1[k]  = op inside {op_reg, op_imm, op_branch, op_jalr};
    assign uses_rs2[k]  = op inside {op_reg, op_branch};
    assign is_ctrl[k]   = op inside {op_branch, op_jal, op_jalr};

    assign issue[k] = '{issued: issued[k],
                        instr:  bundle_q.words[k],
                        pc:     pc_q + xlen'(4 * k)};
  end

  // Lane k issues only behind an issued, non-control lane with no RAW hazard
  always_comb begin
    issued    = '0;
    issued[0] = (state == execute);
    for (int k = 1; k < lanes; k++) begin
      issued[k] = issued[k-1] && !is_ctrl[k-1];
      for (int j = 0; j < k; j++) begin
        if (writes_rd[j] &&
            ((uses_rs1[k] && (rs1_f[k] == rd_f[j])) ||
             (uses_rs2[k] && (rs2_f[k] == rd_f[j])))) begin
          issued[k] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    issue_cnt = '0;
    for (int k = 0; k < lanes; k++) begin
      issue_cnt = issue_cnt + 2'(issued[k]);
    end
    pc_next = pc_q + (xlen'(issue_cnt) << 2);
    // Only the last issued lane can redirect
    for (int k = 0; k < lanes; k++) begin
      if (issued[k] && results[k].redirect) begin
        pc_next = {results[k].target[xlen-1:1], 1'b0};
      end
    end
  end

endmodule

//--- rtl/exec_lane.sv
// One execution lane: decode, immediate, operand select, ALU and
// branch resolution for a single issued word
`timescale 1ns/1ns

module exec_lane
  import rv_core_pkg::*;
(
  input  lane_issue_t  issue,
  output reg_read_t    rd_req,
  input  reg_data_t    rd_data,
  output lane_result_t result
);

  logic [instr_w-1:0] ins;
  rv_opcode_e         op;
  logic [2:0]         funct3;
  logic [xlen-1:0]    imm;
  logic [xlen-1:0]    op_a;
  logic [xlen-1:0]    op_b;
  logic [xlen-1:0]    alu_out;
  alu_op_e            alu_op;
  logic               legal_wr;
  logic               taken;

  assign ins    = issue.instr;
  assign op     = rv_opcode_e'(ins[6:0]);
  assign funct3 = ins[14:12];

  assign rd_req.rs1    = ins[19:15];
  assign rd_req.rs2    = ins[24:20];
  assign rd_req.rs1_en = op inside {op_reg, op_imm, op_branch, op_jalr}; // LUI reads zero
  assign rd_req.rs2_en = op inside {op_reg, op_branch};

  always_comb begin
    case (op)
      op_imm, op_jalr:  imm = {{20{ins[31]}}, ins[31:20]};
      op_branch:        imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      op_lui, op_auipc: imm = {ins[31:12], 12'b0};
      op_jal:           imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      default:          imm = '0;
    endcase
  end

  assign op_a = (op inside {op_branch, op_auipc, op_jal}) ? issue.pc : rd_data.rs1_data;
  assign op_b = (op == op_reg) ? rd_data.rs2_data : imm;

  always_comb begin
    if ((op == op_reg) || ((op == op_imm) && (funct3 == 3'b101))) begin
      alu_op = alu_op_e'({ins[30], funct3}); // Sub and arithmetic shift use bit 30
    end else if (op == op_imm) begin
      alu_op = alu_op_e'({1'b0, funct3});
    end else begin
      alu_op = alu_add; // Addresses, upper immediates, targets
    end
  end

  always_comb begin
    case (alu_op)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_sll:  alu_out = op_a << op_b[4:0];
      alu_slt:  alu_out = xlen'($signed(op_a) < $signed(op_b));
      alu_sltu: alu_out = xlen'(op_a < op_b);
      alu_xor:  alu_out = op_a ^ op_b;
      alu_srl:  alu_out = op_a >> op_b[4:0];
      alu_sra:  alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
      alu_or:   alu_out = op_a | op_b;
      alu_and:  alu_out = op_a & op_b;
      default:  alu_out = '0;
    endcase
  end

  // Legal encodings that write rd; MUL/DIV fail the funct7 check
  always_comb begin
    case (op)
      op_reg:  legal_wr = ({ins[31], ins[29:25]} == 6'b0);
      op_imm:  legal_wr = ((funct3 == 3'b001) && (ins[31:25] == 7'b0)) ||
                          ((funct3 == 3'b101) && ({ins[31], ins[29:25]} == 6'b0)) ||
                          ((funct3 != 3'b001) && (funct3 != 3'b101));
      op_lui, op_auipc, op_jal, op_jalr: legal_wr = 1'b1;
      default: legal_wr = 1'b0;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  taken = (rd_data.rs1_data == rd_data.rs2_data);
      3'b001:  taken = (rd_data.rs1_data != rd_data.rs2_data);
      3'b100:  taken = ($signed(rd_data.rs1_data) < $signed(rd_data.rs2_data));
      3'b101:  taken = ($signed(rd_data.rs1_data) >= $signed(rd_data.rs2_data));
      3'b110:  taken = (rd_data.rs1_data < rd_data.rs2_data);
      3'b111:  taken = (rd_data.rs1_data >= rd_data.rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign result.wen      = issue.issued && legal_wr;
  assign result.rd       = ins[11:7];
  assign result.data     = (op inside {op_jal, op_jalr}) ? issue.pc + xlen'(4) : alu_out;
  assign result.redirect = issue.issued &&
                           (((op == op_branch) && taken) || (op == op_jal) || (op == op_jalr));
  assign result.target   = alu_out; // Bit 0 cleared by the issue unit

endmodule

//--- rtl/register_file.sv
// Integer register file x1..x31 with two read ports per lane and
// one write port per lane, later lanes taking priority
`timescale 1ns/1ns

module register_file
  import rv_core_pkg::*;
(
  input  logic         clock,
  input  logic         reset_n,
  input  reg_read_t    rd_req  [lanes],
  output reg_data_t    rd_data [lanes],
  input  lane_result_t results [lanes]
);

  localparam int num_regs = 2 ** reg_addr_w;

  logic [xlen-1:0] regs [1:num_regs-1];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 1; r < num_regs; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // Higher lane comes later in program order and overrides
      for (int k = 0; k < lanes; k++) begin
        if (results[k].wen && (results[k].rd != '0)) begin
          regs[results[k].rd] <= results[k].data;
        end
      end
    end
  end

  for (genvar k = 0; k < lanes; k++) begin : rd_gen
    assign rd_data[k].rs1_data = (rd_req[k].rs1_en && (rd_req[k].rs1 != '0)) ?
                                 regs[rd_req[k].rs1] : '0; // x0 reads zero
    assign rd_data[k].rs2_data = (rd_req[k].rs2_en && (rd_req[k].rs2 != '0)) ?
                                 regs[rd_req[k].rs2] : '0;
  end

endmodule

//--- rtl/rv32i_triple_issue_core.sv
// Top of the three-lane RV32I core: issue unit, generated lanes,
// register file and the per-lane commit outputs
`timescale 1ns/1ns

module rv32i_triple_issue_core
  import rv_core_pkg::*;
(
  input  logic            clock,
  input  logic            reset_n,
  output logic            fetch_req,
  output logic [xlen-1:0] fetch_pc,
  input  logic            fetch_ack,
  input  fetch_bundle_t   fetch_words,
  output commit_t         commits [lanes]
);

  lane_issue_t  issue   [lanes];
  lane_result_t results [lanes];
  reg_read_t    rd_req  [lanes];
  reg_data_t    rd_data [lanes];

  bundle_issue issue_unit (
    .clock       (clock),
    .reset_n     (reset_n),
    .fetch_req   (fetch_req),
    .fetch_pc    (fetch_pc),
    .fetch_ack   (fetch_ack),
    .fetch_words (fetch_words),
    .issue       (issue),
    .results     (results)
  );

  for (genvar k = 0; k < lanes; k++) begin : lane_gen
    exec_lane lane (
      .issue   (issue[k]),
      .rd_req  (rd_req[k]),
      .rd_data (rd_data[k]),
      .result  (results[k])
    );

    assign commits[k].valid = issue[k].issued; // Only during execute
    assign commits[k].pc    = issue[k].pc;
    assign commits[k].wen   = results[k].wen;
    assign commits[k].rd    = results[k].rd;
    assign commits[k].data  = results[k].data;
  end

  register_file rf (
    .clock   (clock),
    .reset_n (reset_n),
    .rd_req  (rd_req),
    .rd_data (rd_data),
    .results (results)
  );

endmodule

//--- rtl/rv_core_pkg.sv
// Shared widths, opcode, ALU and fetch-state enums, and the structs that
// pass between the issue unit, the execution lanes and the register file
package rv_core_pkg;

  localparam int xlen       = 32;
  localparam int lanes      = 3;
  localparam int reg_addr_w = 5;
  localparam int instr_w    = 32;

  // RV32I major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_load   = 7'b0000011, // Executes as a no-op
    op_store  = 7'b0100011, // Executes as a no-op
    op_fence  = 7'b0001111, // Executes as a no-op
    op_system = 7'b1110011  // Executes as a no-op
  } rv_opcode_e;

  // ALU function as {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_e;

  typedef enum logic [1:0] {
    fetch_request,
    fetch_release,
    execute
  } fetch_state_e;

  typedef struct packed {
    logic [lanes-1:0][instr_w-1:0] words; // words[k] sits at fetch_pc + 4k
  } fetch_bundle_t;

  typedef struct packed {
    logic               issued;
    logic [instr_w-1:0] instr;
    logic [xlen-1:0]    pc;
  } lane_issue_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic                  rs1_en;
    logic                  rs2_en;
  } reg_read_t;

  typedef struct packed {
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
  } reg_data_t;

  typedef struct packed {
    logic                  wen;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic                  redirect;
    logic [xlen-1:0]       target;
  } lane_result_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic                  wen;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } commit_t;

endpackage

//--- testbench/core_properties.sv
// Concurrent checks on the fetch handshake and on commit ordering,
// bound into the core top level
`timescale 1ns/1ns

module core_properties
  import rv_core_pkg::*;
(
  input logic            clock,
  input logic            reset_n,
  input logic            fetch_req,
  input logic [xlen-1:0] fetch_pc,
  input logic            fetch_ack,
  input commit_t         commits [lanes]
);

  req_low_in_reset: assert property (@(posedge clock) !reset_n |-> !fetch_req)
    else $error("fetch_req high during reset");

  // Request held until the environment answers
  req_held: assert property (@(posedge clock) disable iff (!reset_n)
    (fetch_req && !fetch_ack) |=> fetch_req)
    else $error("fetch_req dropped before fetch_ack");

  pc_stable: assert property (@(posedge clock) disable iff (!reset_n)
    (fetch_req || fetch_ack) |=> $stable(fetch_pc))
    else $error("fetch_pc changed during a handshake");

  lane1_in_order: assert property (@(posedge clock) disable iff (!reset_n)
    commits[1].valid |-> commits[0].valid)
    else $error("lane 1 committed without lane 0");

  lane2_in_order: assert property (@(posedge clock) disable iff (!reset_n)
    commits[2].valid |-> commits[1].valid)
    else $error("lane 2 committed without lane 1");

endmodule

bind rv32i_triple_issue_core core_properties props0 (.*);

//--- testbench/core_stim.txt
# P: three program words from address 0 upward, B: issue count of a bundle
# C: commit pc, wen, rd (decimal), data; rd and data ignored when wen is 0
P 00500093 ff800113 123451b7
P 00208233 401152b3 00115333
P 001123b3 00113433 00138493
P 06408013 00700513 000065b3
P 00100613 00200613 00001697
P 00060733 00208463 00209663
P 06300793 06300793 0080086f
P 06300793 00002883 02208933
P 068089e7 06300793 06300793
P fff74a13 0000006f 06300793
# Independent trio
B 3
C 00000000 1 01 00000005
C 00000004 1 02 fffffff8
C 00000008 1 03 12345000
# add, sra and srl on a negative value
B 3
C 0000000c 1 04 fffffffd
C 00000010 1 05 ffffffff
C 00000014 1 06 07ffffff
# slt against sltu, then addi reading x7 is held back
B 2
C 00000018 1 07 00000001
C 0000001c 1 08 00000000
B 3
C 00000020 1 09 00000002
C 00000024 1 00 00000069
C 00000028 1 10 00000007
# x0 reads zero, two writes of x12
B 3
C 0000002c 1 11 00000000
C 00000030 1 12 00000001
C 00000034 1 12 00000002
# auipc, later x12 value, beq not taken
B 3
C 00000038 1 13 00001038
C 0000003c 1 14 00000002
C 00000040 0 00 00000000
# bne taken to 0x50
B 1
C 00000044 0 00 00000000
# jal to 0x58
B 1
C 00000050 1 16 00000054
# load and mul as no-ops, jalr to 0x6d with bit 0 cleared
B 3
C 00000058 0 00 00000000
C 0000005c 0 00 00000000
C 00000060 1 19 00000064
B 2
C 0000006c 1 20 fffffffd
C 00000070 1 00 00000074
# Jump to self
B 1
C 00000070 1 00 00000074

//--- testbench/core_tb.sv
// Testbench for the three-lane core with an instruction memory model of
// random ack delay and stim-file driven commit and issue-count checks
`timescale 1ns/1ns

module core_tb;
  import rv_core_pkg::*;

  localparam int mem_words = 64;
  localparam int max_wait  = 50; // Cycles per wait loop

  logic          clock;
  logic          reset_n;
  logic          fetch_req;
  logic [31:0]   fetch_pc;
  logic          fetch_ack;
  fetch_bundle_t fetch_words;
  commit_t       commits [lanes];

  logic [31:0] mem [mem_words];
  int          exp_count [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_data [$];
  int          exp_wen [$];
  int          exp_rd [$];
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  integer      seed = 32'h3c83_23f5;

  rv32i_triple_issue_core dut0 (.*);

  always #5 clock = ~clock;

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (addr[31:2] < mem_words) return mem[addr[31:2]];
    return 32'h0bad_0000 ^ addr; // Outside the loaded range
  endfunction

  task automatic load_stim();
    int          fd;
    byte         tag;
    string       line;
    logic [31:0] w0, w1, w2, d;
    int          n, wen, rd, cnt;
    n = 0;
    for (int i = 0; i < mem_words; i++) mem[i] = 32'h0bad_0000 | (i << 2);
    fd = $fopen("testbench/core_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/core_stim.txt");
      errors++;
      return;
    end
    while ($fscanf(fd, " %c", tag) == 1) begin
      case (tag)
        "#": void'($fgets(line, fd)); // Comment line
        "P": begin
          void'($fscanf(fd, "%h %h %h", w0, w1, w2));
          mem[n] = w0;
          mem[n+1] = w1;
          mem[n+2] = w2;
          n += 3;
        end
        "B": begin
          void'($fscanf(fd, "%d", cnt));
          exp_count.push_back(cnt);
        end
        "C": begin
          void'($fscanf(fd, "%h %d %d %h", w0, wen, rd, d));
          exp_pc.push_back(w0);
          exp_wen.push_back(wen);
          exp_rd.push_back(rd);
          exp_data.push_back(d);
        end
        default: begin
          $display("unknown tag in stim file");
          errors++;
        end
      endcase
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got, inout bit ok);
    assert (got === exp_v) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got);
      errors++;
      ok = 0;
    end
  endtask

  // Instruction memory, one four-phase handshake per request
  initial begin : memory_model
    int n;
    int delay;
    @(posedge reset_n);
    forever begin
      for (n = 0; n < max_wait && !fetch_req; n++) @(negedge clock);
      if (!fetch_req) begin
        $display("timeout waiting for fetch_req to rise");
        errors++;
        disable memory_model;
      end
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(negedge clock);
      fetch_words.words[0] = word_at(fetch_pc);
      fetch_words.words[1] = word_at(fetch_pc + 4);
      fetch_words.words[2] = word_at(fetch_pc + 8);
      fetch_ack = 1'b1;
      for (n = 0; n < max_wait && fetch_req; n++) @(negedge clock);
      if (fetch_req) begin
        $display("timeout waiting for fetch_req to fall");
        errors++;
        disable memory_model;
      end
      fetch_ack = 1'b0;
    end
  end

  initial begin
    bit ok;
    int n;
    int cnt;
    clock = 1'b0;
    reset_n = 1'b0;
    fetch_ack = 1'b0;
    fetch_words = '0;
    load_stim();
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;

    ok = 1;
    for (n = 0; n < max_wait && !fetch_req; n++) @(negedge clock);
    assert (fetch_req) else begin
      $display("first fetch request never appeared");
      errors++;
      ok = 0;
    end
    check_value("fetch_pc", 32'h0, fetch_pc, ok);
    if (ok) passed++;
    else failed++;
    $display("first request: %s", ok ? "ok" : "FAILED");

    foreach (exp_count[b]) begin
      ok = 1;
      for (n = 0; n < max_wait && !commits[0].valid; n++) @(negedge clock);
      if (!commits[0].valid) begin
        $display("bundle %0d: no commit within %0d cycles", b, max_wait);
        errors++;
        failed++;
        break;
      end
      cnt = 0;
      for (int k = 0; k < lanes; k++) cnt += commits[k].valid;
      check_value("issue_count", exp_count[b], cnt, ok);
      if (exp_pc.size() > 0) begin
        check_value("fetch_pc", exp_pc[0], fetch_pc, ok); // Target or sequential pc
      end
      for (int k = 0; k < cnt && exp_pc.size() > 0; k++) begin
        check_value("commit.pc", exp_pc[0], commits[k].pc, ok);
        check_value("commit.wen", exp_wen[0], commits[k].wen, ok);
        if (exp_wen[0] != 0) begin // Branches and no-ops carry no rd/data
          check_value("commit.rd", exp_rd[0], commits[k].rd, ok);
          check_value("commit.data", exp_data[0], commits[k].data, ok);
        end
        void'(exp_pc.pop_front());
        void'(exp_wen.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
      end
      if (ok) passed++;
      else failed++;
      $display("bundle %0d at pc %h: %s", b, commits[0].pc, ok ? "ok" : "FAILED");
      @(negedge clock);
    end

    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
